/* Bender.yml */
package:
  name: dcache

sources:
  - hw/cachePkg.sv
  - hw/memBusPkg.sv
  - hw/dataSram.sv
  - hw/tagStore.sv
  - hw/refillBuffer.sv
  - hw/dcacheCtrl.sv
  - hw/dcacheTop.sv
  - target: test
    files:
      - verification/dcacheTb.sv

/* dcacheTop.f */
hw/cachePkg.sv
hw/memBusPkg.sv
hw/dataSram.sv
hw/tagStore.sv
hw/refillBuffer.sv
hw/dcacheCtrl.sv
hw/dcacheTop.sv
verification/dcacheTb.sv

/* hw/cachePkg.sv */
package cachePkg;

  // byte address split: tag | index | offset
  localparam int AddrWidth    = 32;
  localparam int TagWidth     = 21;
  localparam int IndexWidth   = 6;
  localparam int OffsetWidth  = 5;

  // two ways of 64 sets, four doublewords per line
  localparam int NumSets      = 64;
  localparam int LineWidth    = 256;
  localparam int WordWidth    = 64;
  localparam int WordsPerLine = 4;

  // a line is stored as two SRAM halves
  localparam int SramWidth    = 128;

  // raw view for the ports, field view for the arrays
  typedef union packed {
    logic [AddrWidth-1:0] raw;
    struct packed {
      logic [TagWidth-1:0]    tag;
      logic [IndexWidth-1:0]  index;
      logic [OffsetWidth-1:0] offset;
    } f;
  } cacheAddr_u;

  typedef logic [WordWidth-1:0] dword_t;
  typedef logic [LineWidth-1:0] line_t;
  typedef logic [7:0]           byteMask_t;

endpackage

/* hw/dataSram.sv */
`timescale 1ns/1ps

module dataSram import cachePkg::*; (
  input  logic                  clk,
  input  logic                  en_i,
  input  logic                  we_i,
  input  logic [IndexWidth-1:0] addr_i,
  input  logic [SramWidth-1:0]  wrData_i,
  input  logic [SramWidth-1:0]  wrMask_i,
  output logic [SramWidth-1:0]  rdData_o
);

  logic [SramWidth-1:0] mem [NumSets];

  // bit-granular write, untouched bits keep their old value
  always_ff @(posedge clk) begin
    if (en_i && we_i) begin
      mem[addr_i] <= (mem[addr_i] & ~wrMask_i) | (wrData_i & wrMask_i);
    end
  end

  // registered read, output holds while the macro is idle or writing
  always_ff @(posedge clk) begin
    if (en_i && !we_i) begin
      rdData_o <= mem[addr_i];
    end
  end

endmodule

/* hw/dcacheCtrl.sv */
`timescale 1ns/1ps

module dcacheCtrl
  import cachePkg::*;
  import memBusPkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  // pipeline
  input  logic                  valid_i,
  input  logic                  isStore_i,
  input  logic [AddrWidth-1:0]  addr_i,
  input  dword_t                storeData_i,
  input  byteMask_t             storeMask_i,
  output logic                  addrOk_o,
  output logic                  dataOk_o,
  output dword_t                loadData_o,
  // tag store
  input  logic                  way1Hit_i,
  input  logic                  way2Hit_i,
  input  logic                  victimDirty_i,
  input  logic [AddrWidth-1:0]  victimAddr_i,
  output logic [IndexWidth-1:0] lookupIndex_o,
  output logic [TagWidth-1:0]   lookupTag_o,
  output logic                  tagWe_o,
  output logic                  wayWe_o,
  output logic                  setDirty_o,
  output logic                  clearDirty_o,
  output logic                  hitWay_o,
  output logic                  victimWay_o,
  // data SRAMs
  input  logic [SramWidth-1:0]  way1LoData_i,
  input  logic [SramWidth-1:0]  way1HiData_i,
  input  logic [SramWidth-1:0]  way2LoData_i,
  input  logic [SramWidth-1:0]  way2HiData_i,
  output logic                  way1En_o,
  output logic                  way1We_o,
  output logic                  way2En_o,
  output logic                  way2We_o,
  output logic [IndexWidth-1:0] sramAddr_o,
  output logic [SramWidth-1:0]  sramLoData_o,
  output logic [SramWidth-1:0]  sramHiData_o,
  output logic [SramWidth-1:0]  sramLoMask_o,
  output logic [SramWidth-1:0]  sramHiMask_o,
  // refill buffer
  output logic                  beatValid_o,
  output logic                  beatLast_o,
  output logic                  clearBuffer_o,
  output logic                  mergeStore_o,
  output logic [1:0]            wordSel_o,
  output dword_t                storeData_o,
  output byteMask_t             storeMask_o,
  input  line_t                 refillLine_i,
  // memory
  output logic                  memRdValid_o,
  output logic [AddrWidth-1:0]  memRdAddr_o,
  input  logic                  memRdReady_i,
  input  logic                  memRdDataValid_i,
  input  logic                  memRdLast_i,
  output logic                  memWrValid_o,
  output logic [AddrWidth-1:0]  memWrAddr_o,
  output logic [WriteWidth-1:0] memWrData_o,
  input  logic                  memWrReady_i
);

  enum logic [2:0] {Idle, Compare, WriteBack, Request, Refill, Install} stateQ, stateD;

  cacheAddr_u           inAddr;
  cacheAddr_u           reqQ;
  cacheAddr_u           rdAddr;
  logic                 isStoreQ;
  dword_t               storeDataQ;
  byteMask_t            storeMaskQ;
  logic                 victimWayQ;
  logic [3:0]           lfsrQ;
  logic                 accept;
  logic                 hit;
  logic                 storeHit;
  logic                 install;
  logic [WordWidth-1:0] byteBits;
  line_t                laneMask;
  line_t                hitLine;
  line_t                srcLine;

  assign inAddr.raw = addr_i;
  assign accept     = valid_i && addrOk_o;
  assign hit        = way1Hit_i || way2Hit_i;
  assign storeHit   = (stateQ == Compare) && hit && isStoreQ;
  assign install    = (stateQ == Install);

  // a store hit owns the SRAM port in compare, so no new request then
  assign addrOk_o = (stateQ == Idle) || ((stateQ == Compare) && hit && !isStoreQ);
  assign dataOk_o = ((stateQ == Compare) && hit) || install;

  // request latch
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      isStoreQ <= 1'b0;
    end else if (accept) begin
      isStoreQ <= isStore_i;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      reqQ       <= inAddr;
      storeDataQ <= storeData_i;
      storeMaskQ <= storeMask_i;
    end
  end

  // x^4 + x^3 + 1, free running
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lfsrQ      <= 4'b0001;
      victimWayQ <= 1'b0;
    end else begin
      lfsrQ <= {lfsrQ[2:0], lfsrQ[3] ^ lfsrQ[2]};
      if ((stateQ == Compare) && !hit) begin
        victimWayQ <= lfsrQ[0];
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      stateQ <= Idle;
    end else begin
      stateQ <= stateD;
    end
  end

  always_comb begin
    stateD = stateQ;
    case (stateQ)
      Idle: begin
        if (valid_i) begin
          stateD = Compare;
        end
      end
      Compare: begin
        if (!hit) begin
          stateD = victimDirty_i ? WriteBack : Request;
        end else if (isStoreQ || !valid_i) begin
          stateD = Idle;
        end
      end
      WriteBack: begin
        if (memWrReady_i) begin
          stateD = Request;
        end
      end
      Request: begin
        if (memRdReady_i) begin
          stateD = Refill;
        end
      end
      Refill: begin
        if (memRdDataValid_i && memRdLast_i) begin
          stateD = Install;
        end
      end
      Install: begin
        stateD = Idle;
      end
      default: begin
        stateD = Idle;
      end
    endcase
  end

  // tag store control
  assign lookupIndex_o = reqQ.f.index;
  assign lookupTag_o   = reqQ.f.tag;
  assign tagWe_o       = install;
  assign wayWe_o       = victimWayQ;
  assign hitWay_o      = way2Hit_i;
  // in compare the dirty check must already see the way about to be picked
  assign victimWay_o   = (stateQ == Compare) ? lfsrQ[0] : victimWayQ;
  assign setDirty_o    = storeHit || (install && isStoreQ);
  assign clearDirty_o  = install && !isStoreQ;

  // reads launch on acceptance with the incoming index, writes use the latch
  assign way1We_o   = (storeHit && way1Hit_i) || (install && !victimWayQ);
  assign way2We_o   = (storeHit && way2Hit_i) || (install && victimWayQ);
  assign way1En_o   = accept || way1We_o;
  assign way2En_o   = accept || way2We_o;
  assign sramAddr_o = accept ? inAddr.f.index : reqQ.f.index;

  always_comb begin
    for (int b = 0; b < 8; b++) begin
      byteBits[8*b +: 8] = {8{storeMaskQ[b]}};
    end
  end

  // byte strobes moved to the addressed doubleword of the line
  assign laneMask = line_t'(byteBits) << (reqQ.f.offset[4:3] * WordWidth);

  // store data already sits in its lane, so both copies line up with the mask
  assign sramLoData_o = install ? refillLine_i[SramWidth-1:0] : {2{storeDataQ}};
  assign sramHiData_o = install ? refillLine_i[LineWidth-1:SramWidth] : {2{storeDataQ}};
  assign sramLoMask_o = install ? '1 : laneMask[SramWidth-1:0];
  assign sramHiMask_o = install ? '1 : laneMask[LineWidth-1:SramWidth];

  // load data from the hitting way, or straight from the refill on a miss
  assign hitLine    = way2Hit_i ? {way2HiData_i, way2LoData_i} : {way1HiData_i, way1LoData_i};
  assign srcLine    = install ? refillLine_i : hitLine;
  assign loadData_o = srcLine[reqQ.f.offset[4:3] * WordWidth +: WordWidth];

  // refill buffer control
  assign beatValid_o   = (stateQ == Refill) && memRdDataValid_i;
  assign beatLast_o    = memRdLast_i;
  assign clearBuffer_o = (stateQ == Compare) && !hit;
  assign mergeStore_o  = isStoreQ;
  assign wordSel_o     = reqQ.f.offset[4:3];
  assign storeData_o   = storeDataQ;
  assign storeMask_o   = storeMaskQ;

  always_comb begin
    rdAddr          = reqQ;
    rdAddr.f.offset = '0;
  end

  assign memRdValid_o = (stateQ == Request);
  assign memRdAddr_o  = rdAddr.raw;
  assign memWrValid_o = (stateQ == WriteBack);
  assign memWrAddr_o  = victimAddr_i;
  // SRAM outputs still hold the set read at acceptance
  assign memWrData_o  = victimWayQ ? {way2HiData_i, way2LoData_i}
                                   : {way1HiData_i, way1LoData_i};

  rdWrExclusive: assert property (@(posedge clk) disable iff (!rst_n)
    !(memRdValid_o && memWrValid_o));

  noDataOkInIdle: assert property (@(posedge clk) disable iff (!rst_n)
    (stateQ == Idle) |-> !dataOk_o);

endmodule

/* hw/dcacheTop.sv */
`timescale 1ns/1ps

module dcacheTop
  import cachePkg::*;
  import memBusPkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  valid_i,
  input  logic                  isStore_i,
  input  logic [AddrWidth-1:0]  addr_i,
  input  dword_t                storeData_i,
  input  byteMask_t             storeMask_i,
  output logic                  addrOk_o,
  output logic                  dataOk_o,
  output dword_t                loadData_o,
  output logic                  memRdValid_o,
  output logic [AddrWidth-1:0]  memRdAddr_o,
  input  logic                  memRdReady_i,
  input  logic [BeatWidth-1:0]  memRdData_i,
  input  logic                  memRdDataValid_i,
  input  logic                  memRdLast_i,
  output logic                  memWrValid_o,
  output logic [AddrWidth-1:0]  memWrAddr_o,
  output logic [WriteWidth-1:0] memWrData_o,
  input  logic                  memWrReady_i
);

  logic                  way1Hit;
  logic                  way2Hit;
  logic                  victimDirty;
  logic [AddrWidth-1:0]  victimAddr;
  logic [IndexWidth-1:0] lookupIndex;
  logic [TagWidth-1:0]   lookupTag;
  logic                  tagWe;
  logic                  wayWe;
  logic                  setDirty;
  logic                  clearDirty;
  logic                  hitWay;
  logic                  victimWay;
  // indexed [way][half], half 0 is the low 128 bits of the line
  logic [1:0][1:0][SramWidth-1:0] sramRdData;
  logic [1:0]                     sramEn;
  logic [1:0]                     sramWe;
  logic [1:0][SramWidth-1:0]      sramWrData;
  logic [1:0][SramWidth-1:0]      sramMask;
  logic [IndexWidth-1:0]          sramAddr;
  logic                  beatValid;
  logic                  beatLast;
  logic                  clearBuffer;
  logic                  mergeStore;
  logic [1:0]            wordSel;
  dword_t                storeDataQ;
  byteMask_t             storeMaskQ;
  line_t                 refillLine;

  dcacheCtrl i_dcacheCtrl (
    .clk              (clk),
    .rst_n            (rst_n),
    .valid_i          (valid_i),
    .isStore_i        (isStore_i),
    .addr_i           (addr_i),
    .storeData_i      (storeData_i),
    .storeMask_i      (storeMask_i),
    .addrOk_o         (addrOk_o),
    .dataOk_o         (dataOk_o),
    .loadData_o       (loadData_o),
    .way1Hit_i        (way1Hit),
    .way2Hit_i        (way2Hit),
    .victimDirty_i    (victimDirty),
    .victimAddr_i     (victimAddr),
    .lookupIndex_o    (lookupIndex),
    .lookupTag_o      (lookupTag),
    .tagWe_o          (tagWe),
    .wayWe_o          (wayWe),
    .setDirty_o       (setDirty),
    .clearDirty_o     (clearDirty),
    .hitWay_o         (hitWay),
    .victimWay_o      (victimWay),
    .way1LoData_i     (sramRdData[0][0]),
    .way1HiData_i     (sramRdData[0][1]),
    .way2LoData_i     (sramRdData[1][0]),
    .way2HiData_i     (sramRdData[1][1]),
    .way1En_o         (sramEn[0]),
    .way1We_o         (sramWe[0]),
    .way2En_o         (sramEn[1]),
    .way2We_o         (sramWe[1]),
    .sramAddr_o       (sramAddr),
    .sramLoData_o     (sramWrData[0]),
    .sramHiData_o     (sramWrData[1]),
    .sramLoMask_o     (sramMask[0]),
    .sramHiMask_o     (sramMask[1]),
    .beatValid_o      (beatValid),
    .beatLast_o       (beatLast),
    .clearBuffer_o    (clearBuffer),
    .mergeStore_o     (mergeStore),
    .wordSel_o        (wordSel),
    .storeData_o      (storeDataQ),
    .storeMask_o      (storeMaskQ),
    .refillLine_i     (refillLine),
    .memRdValid_o     (memRdValid_o),
    .memRdAddr_o      (memRdAddr_o),
    .memRdReady_i     (memRdReady_i),
    .memRdDataValid_i (memRdDataValid_i),
    .memRdLast_i      (memRdLast_i),
    .memWrValid_o     (memWrValid_o),
    .memWrAddr_o      (memWrAddr_o),
    .memWrData_o      (memWrData_o),
    .memWrReady_i     (memWrReady_i)
  );

  tagStore i_tagStore (
    .clk           (clk),
    .rst_n         (rst_n),
    .index_i       (lookupIndex),
    .tag_i         (lookupTag),
    .tagWe_i       (tagWe),
    .wayWe_i       (wayWe),
    .setDirty_i    (setDirty),
    .clearDirty_i  (clearDirty),
    .hitWay_i      (hitWay),
    .victimWay_i   (victimWay),
    .way1Hit_o     (way1Hit),
    .way2Hit_o     (way2Hit),
    .victimDirty_o (victimDirty),
    .victimAddr_o  (victimAddr)
  );

  refillBuffer i_refillBuffer (
    .clk           (clk),
    .rst_n         (rst_n),
    .beatValid_i   (beatValid),
    .beatLast_i    (beatLast),
    .beatData_i    (memRdData_i),
    .clearBuffer_i (clearBuffer),
    .mergeStore_i  (mergeStore),
    .wordSel_i     (wordSel),
    .storeData_i   (storeDataQ),
    .storeMask_i   (storeMaskQ),
    .refillLine_o  (refillLine)
  );

  // way 1 low, way 1 high, way 2 low, way 2 high
  for (genvar w = 0; w < 2; w++) begin : g_way
    for (genvar h = 0; h < 2; h++) begin : g_half
      dataSram i_dataSram (
        .clk      (clk),
        .en_i     (sramEn[w]),
        .we_i     (sramWe[w]),
        .addr_i   (sramAddr),
        .wrData_i (sramWrData[h]),
        .wrMask_i (sramMask[h]),
        .rdData_o (sramRdData[w][h])
      );
    end
  end

endmodule

/* hw/memBusPkg.sv */
package memBusPkg;

  // refill comes back as a burst of doublewords
  localparam int BeatWidth  = 64;
  localparam int BurstLen   = 4;

  // a dirty victim leaves in a single transfer
  localparam int WriteWidth = BeatWidth * BurstLen;

  typedef logic [$clog2(BurstLen)-1:0] beatCount_t;

endpackage

/* hw/refillBuffer.sv */
`timescale 1ns/1ps

module refillBuffer
  import cachePkg::*;
  import memBusPkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       beatValid_i,
  input  logic       beatLast_i,
  input  dword_t     beatData_i,
  input  logic       clearBuffer_i,
  input  logic       mergeStore_i,
  input  logic [1:0] wordSel_i,
  input  dword_t     storeData_i,
  input  byteMask_t  storeMask_i,
  output line_t      refillLine_o
);

  logic [WordsPerLine-1:0][WordWidth-1:0] wordsQ;
  logic [WordsPerLine-1:0][WordWidth-1:0] wordsD;
  beatCount_t                             beatCntQ;
  logic                                   lastSeenQ;

  always_comb begin
    wordsD = wordsQ;
    if (beatValid_i) begin
      wordsD[beatCntQ] = beatData_i;
      // pending store bytes win over the refilled data
      if (beatLast_i && mergeStore_i) begin
        for (int b = 0; b < 8; b++) begin
          if (storeMask_i[b]) begin
            wordsD[wordSel_i][8*b +: 8] = storeData_i[8*b +: 8];
          end
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    wordsQ <= wordsD;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      beatCntQ  <= '0;
      lastSeenQ <= 1'b0;
    end else if (clearBuffer_i) begin
      beatCntQ  <= '0;
      lastSeenQ <= 1'b0;
    end else if (beatValid_i) begin
      beatCntQ  <= beatCntQ + 1'b1;
      lastSeenQ <= beatLast_i;
    end
  end

  assign refillLine_o = wordsQ;

  // memory must not run past the burst before the next miss
  noBeatAfterLast: assert property (@(posedge clk) disable iff (!rst_n)
    lastSeenQ |-> !beatValid_i);

endmodule

/* hw/tagStore.sv */
`timescale 1ns/1ps

module tagStore import cachePkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [IndexWidth-1:0] index_i,
  input  logic [TagWidth-1:0]   tag_i,
  input  logic                  tagWe_i,
  input  logic                  wayWe_i,
  input  logic                  setDirty_i,
  input  logic                  clearDirty_i,
  input  logic                  hitWay_i,
  input  logic                  victimWay_i,
  output logic                  way1Hit_o,
  output logic                  way2Hit_o,
  output logic                  victimDirty_o,
  output logic [AddrWidth-1:0]  victimAddr_o
);

  logic [TagWidth-1:0] tagMem [2][NumSets];
  logic [NumSets-1:0]  validQ [2];
  logic [NumSets-1:0]  dirtyQ [2];
  logic                dirtyWay;
  cacheAddr_u          victimAddr;

  // install marks the victim way, a store hit marks the hitting way
  assign dirtyWay = tagWe_i ? wayWe_i : hitWay_i;

  always_ff @(posedge clk) begin
    if (tagWe_i) begin
      tagMem[wayWe_i][index_i] <= tag_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      validQ <= '{default: '0};
      dirtyQ <= '{default: '0};
    end else begin
      if (tagWe_i) begin
        validQ[wayWe_i][index_i] <= 1'b1;
      end
      if (setDirty_i) begin
        dirtyQ[dirtyWay][index_i] <= 1'b1;
      end else if (clearDirty_i) begin
        dirtyQ[dirtyWay][index_i] <= 1'b0;
      end
    end
  end

  assign way1Hit_o = validQ[0][index_i] && (tagMem[0][index_i] == tag_i);
  assign way2Hit_o = validQ[1][index_i] && (tagMem[1][index_i] == tag_i);

  // invalid lines are never dirty, so no valid check here
  assign victimDirty_o = dirtyQ[victimWay_i][index_i];

  // write-back address comes from the stored tag, not the request
  always_comb begin
    victimAddr.f.tag    = tagMem[victimWay_i][index_i];
    victimAddr.f.index  = index_i;
    victimAddr.f.offset = '0;
  end

  assign victimAddr_o = victimAddr.raw;

  // a line is only ever installed after both ways missed on it
  noDoubleHit: assert property (@(posedge clk) disable iff (!rst_n)
    !(way1Hit_o && way2Hit_o));

endmodule

/* verification/dcacheTb.sv */
`timescale 1ns/1ps

module dcacheTb
  import cachePkg::*;
  import memBusPkg::*;
();

  // modelled memory window and per-wait cycle limit
  localparam int MemBytes  = 16384;
  localparam int MemWords  = MemBytes / 8;
  localparam int WaitLimit = 200;

  typedef enum logic [1:0] {MustHit, MustMiss, MayMiss} hitKind_e;

  typedef struct packed {
    logic                 isStore;
    logic [AddrWidth-1:0] addr;
    dword_t               data;
    byteMask_t            mask;
    hitKind_e             hitKind;
  } testEntry_t;

  logic                  clk;
  logic                  rst_n;
  logic                  valid;
  logic                  isStore;
  logic [AddrWidth-1:0]  addr;
  dword_t                storeData;
  byteMask_t             storeMask;
  logic                  addrOk;
  logic                  dataOk;
  dword_t                loadData;
  logic                  memRdValid;
  logic [AddrWidth-1:0]  memRdAddr;
  logic                  memRdReady;
  logic [BeatWidth-1:0]  memRdData;
  logic                  memRdDataValid;
  logic                  memRdLast;
  logic                  memWrValid;
  logic [AddrWidth-1:0]  memWrAddr;
  logic [WriteWidth-1:0] memWrData;
  logic                  memWrReady;

  // backMem is what memory holds, refMem what the program has stored
  dword_t     backMem [MemWords];
  dword_t     refMem [MemWords];
  logic       storedLine [MemWords/4];
  testEntry_t tests [$];
  // errors seen per table entry
  int         testErr [$];
  integer     seed = 42772;
  int         cycle = 0;
  int         rdCount = 0;
  int         wrCount = 0;
  int         errors = 0;
  int         passed = 0;
  int         failed = 0;
  logic       hung = 1'b0;
  logic       prevHitLoad = 1'b0;
  int         prevCycle = 0;
  cacheAddr_u lastRdAddr;

  // requests in flight with the oldest at the front
  int     pendIdx [$];
  int     pendCycle [$];
  dword_t pendData [$];
  int     pendRd [$];
  int     pendWr [$];

  dcacheTop i_dcacheTop (
    .clk              (clk),
    .rst_n            (rst_n),
    .valid_i          (valid),
    .isStore_i        (isStore),
    .addr_i           (addr),
    .storeData_i      (storeData),
    .storeMask_i      (storeMask),
    .addrOk_o         (addrOk),
    .dataOk_o         (dataOk),
    .loadData_o       (loadData),
    .memRdValid_o     (memRdValid),
    .memRdAddr_o      (memRdAddr),
    .memRdReady_i     (memRdReady),
    .memRdData_i      (memRdData),
    .memRdDataValid_i (memRdDataValid),
    .memRdLast_i      (memRdLast),
    .memWrValid_o     (memWrValid),
    .memWrAddr_o      (memWrAddr),
    .memWrData_o      (memWrData),
    .memWrReady_i     (memWrReady)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  function automatic int randDelay();
    return $unsigned($random(seed)) % 4;
  endfunction

  task automatic fillMemory();
    for (int i = 0; i < MemWords; i++) begin
      backMem[i] = {$random(seed), $random(seed)};
      refMem[i]  = backMem[i];
    end
    for (int i = 0; i < MemWords / 4; i++) begin
      storedLine[i] = 1'b0;
    end
  endtask

  task automatic addTest(input logic st, input logic [AddrWidth-1:0] a, input dword_t d,
                         input byteMask_t m, input hitKind_e k);
    testEntry_t t;
    t.isStore = st;
    t.addr    = a;
    t.data    = d;
    t.mask    = m;
    t.hitKind = k;
    tests.push_back(t);
    testErr.push_back(0);
  endtask

  task automatic loadTable();
    // cold line at index 8 followed by hits on every doubleword
    addTest(1'b0, 32'h0000_0100, 64'h0, 8'h00, MustMiss);
    addTest(1'b0, 32'h0000_0108, 64'h0, 8'h00, MustHit);
    addTest(1'b0, 32'h0000_0110, 64'h0, 8'h00, MustHit);
    addTest(1'b0, 32'h0000_0118, 64'h0, 8'h00, MustHit);
    addTest(1'b0, 32'h0000_0100, 64'h0, 8'h00, MustHit);
    // partial store hit then a store miss with merge
    addTest(1'b1, 32'h0000_0110, 64'h1122_3344_5566_7788, 8'h0f, MustHit);
    addTest(1'b0, 32'h0000_0110, 64'h0, 8'h00, MustHit);
    addTest(1'b1, 32'h0000_0228, 64'hcafe_f00d_dead_beef, 8'hf0, MustMiss);
    addTest(1'b0, 32'h0000_0228, 64'h0, 8'h00, MustHit);
    addTest(1'b0, 32'h0000_0230, 64'h0, 8'h00, MustHit);
    // three dirty lines on index 3 so the third miss evicts one
    addTest(1'b1, 32'h0000_0068, 64'h0123_4567_89ab_cdef, 8'hff, MustMiss);
    addTest(1'b1, 32'h0000_0870, 64'ha5a5_a5a5_5a5a_5a5a, 8'h3c, MustMiss);
    addTest(1'b1, 32'h0000_1078, 64'hfedc_ba98_7654_3210, 8'hc3, MustMiss);
    addTest(1'b0, 32'h0000_0068, 64'h0, 8'h00, MayMiss);
    addTest(1'b0, 32'h0000_0870, 64'h0, 8'h00, MayMiss);
    addTest(1'b0, 32'h0000_1078, 64'h0, 8'h00, MayMiss);
    addTest(1'b0, 32'h0000_0060, 64'h0, 8'h00, MayMiss);
    // index 8 again with the line dirty from the store hit above
    addTest(1'b0, 32'h0000_0900, 64'h0, 8'h00, MustMiss);
    addTest(1'b0, 32'h0000_1100, 64'h0, 8'h00, MustMiss);
    addTest(1'b0, 32'h0000_0110, 64'h0, 8'h00, MayMiss);
    addTest(1'b0, 32'h0000_0908, 64'h0, 8'h00, MayMiss);
    addTest(1'b1, 32'h0000_0100, 64'h8877_6655_4433_2211, 8'h81, MayMiss);
    addTest(1'b0, 32'h0000_0100, 64'h0, 8'h00, MustHit);
  endtask

  task automatic noteError(input int idx);
    errors++;
    testErr[idx] = testErr[idx] + 1;
  endtask

  task automatic checkIdle(input logic ok, input logic dok, input logic rdv, input logic wrv);
    if (!ok || dok || rdv || wrv) begin
      errors++;
      $display("CHECK FAILED at %0t: idle levels addrOk=%b dataOk=%b rdValid=%b wrValid=%b",
               $time, ok, dok, rdv, wrv);
    end
  endtask

  task automatic checkLoad(input dword_t actual, input dword_t expected, input int idx);
    if (actual !== expected) begin
      noteError(idx);
      $display("CHECK FAILED at %0t: test %0d load data %h, expected %h",
               $time, idx, actual, expected);
    end
  endtask

  task automatic checkReadAddr(input cacheAddr_u actual, input cacheAddr_u expected,
                               input int idx);
    if (actual.raw !== expected.raw) begin
      noteError(idx);
      $display("CHECK FAILED at %0t: test %0d read address %h, expected %h",
               $time, idx, actual.raw, expected.raw);
    end
  endtask

  task automatic checkWriteback(input cacheAddr_u wbAddr, input line_t wbData);
    line_t expLine;
    int    base;
    if (wbAddr.raw >= MemBytes || wbAddr.f.offset != 0 || !storedLine[wbAddr.raw[13:5]]) begin
      errors++;
      $display("CHECK FAILED at %0t: write-back to %h, not a line stored to",
               $time, wbAddr.raw);
    end else begin
      base = wbAddr.raw[13:3];
      for (int k = 0; k < WordsPerLine; k++) begin
        expLine[WordWidth*k +: WordWidth] = refMem[base + k];
      end
      if (wbData !== expLine) begin
        errors++;
        $display("CHECK FAILED at %0t: write-back data for %h is %h, expected %h",
                 $time, wbAddr.raw, wbData, expLine);
      end
    end
  endtask

  task automatic serveWrite();
    cacheAddr_u wbAddr;
    line_t      wbData;
    int         base;
    int         errBefore;
    repeat (randDelay()) @(negedge clk);
    wbAddr.raw = memWrAddr;
    wbData     = memWrData;
    errBefore  = errors;
    checkWriteback(wbAddr, wbData);
    // the only request in flight during a miss is the one that missed
    if (errors != errBefore && pendIdx.size() > 0) begin
      testErr[pendIdx[0]] = testErr[pendIdx[0]] + 1;
    end
    if (wbAddr.raw < MemBytes) begin
      base = wbAddr.raw[13:3];
      for (int k = 0; k < WordsPerLine; k++) begin
        backMem[base + k] = wbData[WordWidth*k +: WordWidth];
      end
    end
    wrCount++;
    memWrReady = 1'b1;
    @(negedge clk);
    memWrReady = 1'b0;
  endtask

  task automatic serveRead();
    int base;
    repeat (randDelay()) @(negedge clk);
    lastRdAddr.raw = memRdAddr;
    base = memRdAddr[13:3];
    rdCount++;
    memRdReady = 1'b1;
    @(negedge clk);
    memRdReady = 1'b0;
    for (int b = 0; b < BurstLen; b++) begin
      repeat (randDelay()) @(negedge clk);
      memRdDataValid = 1'b1;
      memRdData      = backMem[base + b];
      memRdLast      = (b == BurstLen - 1);
      @(negedge clk);
      memRdDataValid = 1'b0;
      memRdLast      = 1'b0;
    end
  endtask

  // memory responder serving a write-back before the refill read
  always begin
    @(negedge clk);
    if (rst_n && memWrValid) begin
      serveWrite();
    end else if (rst_n && memRdValid) begin
      serveRead();
    end
  end

  task automatic recordAccept(input int i, input testEntry_t t);
    int w;
    w = t.addr[13:3];
    pendIdx.push_back(i);
    pendCycle.push_back(cycle);
    pendData.push_back(refMem[w]);
    pendRd.push_back(rdCount);
    pendWr.push_back(wrCount);
    if (prevHitLoad && cycle != prevCycle + 1) begin
      noteError(i);
      $display("test %0d was not accepted in the cycle after the load hit before it", i);
    end
    prevHitLoad = !t.isStore && (t.hitKind == MustHit);
    prevCycle   = cycle;
    if (t.isStore) begin
      for (int b = 0; b < 8; b++) begin
        if (t.mask[b]) begin
          refMem[w][8*b +: 8] = t.data[8*b +: 8];
        end
      end
      storedLine[t.addr[13:5]] = 1'b1;
    end
  endtask

  task automatic completeTest();
    int         idx;
    int         accCycle;
    int         reads;
    int         writes;
    dword_t     expData;
    testEntry_t t;
    cacheAddr_u expAddr;
    if (pendIdx.size() == 0) begin
      errors++;
      $display("dataOk_o pulsed at %0t with no request pending", $time);
    end else begin
      idx      = pendIdx.pop_front();
      accCycle = pendCycle.pop_front();
      expData  = pendData.pop_front();
      reads    = rdCount - pendRd.pop_front();
      writes   = wrCount - pendWr.pop_front();
      t        = tests[idx];
      if (!t.isStore) begin
        checkLoad(loadData, expData, idx);
      end
      if (reads > 1 || writes > 1) begin
        noteError(idx);
        $display("test %0d issued a memory request twice for one miss", idx);
      end
      if (t.hitKind == MustHit && (reads != 0 || cycle - accCycle != 1)) begin
        noteError(idx);
        $display("test %0d should hit but took %0d cycles and %0d reads",
                 idx, cycle - accCycle, reads);
      end
      if (t.hitKind == MustMiss && reads != 1) begin
        noteError(idx);
        $display("test %0d should miss but issued %0d reads", idx, reads);
      end
      if (reads == 1) begin
        expAddr.raw = {t.addr[AddrWidth-1:OffsetWidth], {OffsetWidth{1'b0}}};
        checkReadAddr(lastRdAddr, expAddr, idx);
      end
      $display("test %0d %s %h: %s", idx, t.isStore ? "store" : "load", t.addr,
               (testErr[idx] == 0) ? "ok" : "mismatch");
      if (testErr[idx] == 0) begin
        passed++;
      end else begin
        failed++;
      end
    end
  endtask

  // dataOk_o and loadData_o are sampled half a cycle after the rising edge
  always @(negedge clk) begin
    if (rst_n && !hung) begin
      if (dataOk) begin
        completeTest();
      end else if (pendIdx.size() > 0 && cycle - pendCycle[0] > WaitLimit) begin
        $display("timeout waiting for dataOk_o on test %0d", pendIdx[0]);
        hung = 1'b1;
      end
    end
  end

  initial begin
    testEntry_t t;
    int         n;
    int         errBase;
    valid          = 1'b0;
    isStore        = 1'b0;
    addr           = '0;
    storeData      = '0;
    storeMask      = '0;
    memRdReady     = 1'b0;
    memRdData      = '0;
    memRdDataValid = 1'b0;
    memRdLast      = 1'b0;
    memWrReady     = 1'b0;
    rst_n          = 1'b0;
    fillMemory();
    loadTable();
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    @(negedge clk);
    errBase = errors;
    checkIdle(addrOk, dataOk, memRdValid, memWrValid);
    $display("reset idle levels: %s", (errors == errBase) ? "ok" : "mismatch");
    if (errors == errBase) begin
      passed++;
    end else begin
      failed++;
    end

    // each request is held until the rising edge that accepts it
    for (int i = 0; i < tests.size() && !hung; i++) begin
      t         = tests[i];
      valid     = 1'b1;
      isStore   = t.isStore;
      addr      = t.addr;
      storeData = t.data;
      storeMask = t.mask;
      n = 0;
      while (!addrOk && n < WaitLimit && !hung) begin
        @(negedge clk);
        n++;
      end
      if (!addrOk) begin
        if (!hung) begin
          $display("timeout waiting for addrOk_o on test %0d", i);
        end
        hung = 1'b1;
      end else begin
        recordAccept(i, t);
        @(negedge clk);
      end
    end
    valid = 1'b0;

    n = 0;
    while (pendIdx.size() > 0 && n < WaitLimit && !hung) begin
      @(negedge clk);
      n++;
    end
    if (pendIdx.size() > 0 && !hung) begin
      $display("timeout waiting for dataOk_o on test %0d", pendIdx[0]);
      hung = 1'b1;
    end
    if (!hung && wrCount == 0) begin
      errors++;
      $display("no dirty line was written back during the eviction tests");
    end

    $display("tests: %0d, passed: %0d, failed: %0d, errors: %0d, write-backs: %0d",
             passed + failed, passed, failed, errors, wrCount);
    if (errors == 0 && !hung) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule
